// File: hdl/dbg_target_pkg.sv
package dbg_target_pkg;

    // Word and byte sizes of the debugged core
    localparam int WORD_BITS      = 32;
    localparam int BYTE_BITS      = 8;
    localparam int BYTES_PER_WORD = 4;

    // Memory depths
    localparam int IM_DEPTH = 256; // Program bytes per load
    localparam int RB_DEPTH = 32;  // Registers
    localparam int DM_DEPTH = 32;  // Data words in one dump

    localparam int IM_ADDR_BITS = 8;
    localparam int RB_ADDR_BITS = 5;
    localparam int DM_ADDR_BITS = 5;

    // PC, register and data memory word
    typedef logic [WORD_BITS-1:0] word_t;

    // UART payload
    typedef logic [BYTE_BITS-1:0] byte_t;

endpackage

// File: hdl/dbg_protocol_pkg.sv
package dbg_protocol_pkg;

    // Command bytes from the host
    typedef enum logic [7:0] {
        CMD_WRITE_IM  = 8'd1, // Program bytes follow
        CMD_START     = 8'd2, // Continuous run
        CMD_STEP_MODE = 8'd3,
        CMD_SEND_RB   = 8'd4, // Register bank dump
        CMD_SEND_DM   = 8'd5, // Data memory dump
        CMD_SEND_PC   = 8'd6,
        CMD_STEP      = 8'd7, // One step plus full dump
        CMD_CONTINUE  = 8'd8  // Leave step mode
    } command_t;

    // Sequencer modes
    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_LOAD,
        MODE_READY, // Program loaded, waiting for run or step
        MODE_RUN,
        MODE_STEP,
        MODE_DUMP
    } mode_t;

    // What a dump streams out
    typedef enum logic [1:0] {
        SRC_PC,
        SRC_DM,
        SRC_RB
    } dump_src_t;

endpackage

// File: hdl/debug_cmd_if.sv
interface debug_cmd_if
    import dbg_protocol_pkg::*;
();

    logic     cmd_valid;   // One-cycle command strobe
    command_t cmd;
    logic     load_done;   // Last program byte written
    logic     load_active; // Received bytes go to instruction memory

    modport frontend (
        output cmd_valid,
        output cmd,
        output load_done,
        input  load_active
    );

    modport sequencer (
        input  cmd_valid,
        input  cmd,
        input  load_done,
        output load_active
    );

endinterface

// File: hdl/command_frontend.sv
module command_frontend
    import dbg_target_pkg::*;
    import dbg_protocol_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_rx_done,
    input  byte_t                   i_rx_data,
    debug_cmd_if.frontend           cmd_port,
    output logic                    o_im_write_enable,
    output logic [IM_ADDR_BITS-1:0] o_im_addr,
    output byte_t                   o_im_data
);

    logic [IM_ADDR_BITS-1:0] write_count; // Next program address
    logic                    load_byte;
    logic                    last_byte;

    assign load_byte = i_rx_done && cmd_port.load_active;
    assign last_byte = (write_count == IM_ADDR_BITS'(IM_DEPTH - 1));

    // Bytes outside a load are commands
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            cmd_port.cmd_valid <= 1'b0;
        end else begin
            cmd_port.cmd_valid <= i_rx_done && !cmd_port.load_active;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rx_done) begin
            cmd_port.cmd <= command_t'(i_rx_data);
        end
    end

    // Program load counter and write strobe
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            write_count        <= '0;
            o_im_write_enable  <= 1'b0;
            cmd_port.load_done <= 1'b0;
        end else begin
            o_im_write_enable  <= load_byte;
            cmd_port.load_done <= load_byte && last_byte; // Same cycle as last write
            if (!cmd_port.load_active) begin
                write_count <= '0;
            end else if (load_byte) begin
                // Wrap to zero so the next load starts clean
                write_count <= last_byte ? '0 : write_count + 1'b1;
            end
        end
    end

    // Address and data follow the strobe
    always_ff @(posedge i_clock) begin
        if (load_byte) begin
            o_im_addr <= write_count;
            o_im_data <= i_rx_data;
        end
    end

endmodule

// File: hdl/debug_sequencer.sv
module debug_sequencer
    import dbg_protocol_pkg::*;
(
    input  logic           i_clock,
    input  logic           i_reset,
    input  logic           i_halt,
    debug_cmd_if.sequencer cmd_port,
    output logic           o_dump_req,
    output dump_src_t      o_dump_src,
    input  logic           i_dump_done,
    output logic           o_pipeline_enable,
    output logic           o_step,
    output logic           o_step_mode
);

    mode_t mode;
    logic  step_chain; // Dump was started by a step command

    // Map a dump command to its source
    function automatic dump_src_t cmd_source(input command_t cmd);
        case (cmd)
            CMD_SEND_DM: return SRC_DM;
            CMD_SEND_RB: return SRC_RB;
            default:     return SRC_PC;
        endcase
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mode       <= MODE_IDLE;
            step_chain <= 1'b0;
            o_step     <= 1'b0;
            o_dump_req <= 1'b0;
            o_dump_src <= SRC_PC;
        end else begin
            o_step     <= 1'b0; // Pulses by default
            o_dump_req <= 1'b0;

            case (mode)
                MODE_IDLE: begin
                    if (cmd_port.cmd_valid) begin
                        case (cmd_port.cmd)
                            CMD_WRITE_IM: mode <= MODE_LOAD;
                            CMD_SEND_PC, CMD_SEND_DM, CMD_SEND_RB: begin
                                mode       <= MODE_DUMP;
                                step_chain <= 1'b0;
                                o_dump_req <= 1'b1;
                                o_dump_src <= cmd_source(cmd_port.cmd);
                            end
                            default: ; // Anything else is ignored here
                        endcase
                    end
                end

                MODE_LOAD: begin
                    if (cmd_port.load_done) begin
                        mode <= MODE_READY;
                    end
                end

                MODE_READY: begin
                    if (cmd_port.cmd_valid) begin
                        if (cmd_port.cmd == CMD_START) begin
                            mode <= MODE_RUN;
                        end else if (cmd_port.cmd == CMD_STEP_MODE) begin
                            mode <= MODE_STEP;
                        end
                    end
                end

                MODE_RUN: begin
                    if (i_halt) begin
                        mode <= MODE_IDLE;
                    end
                end

                MODE_STEP: begin
                    if (i_halt) begin
                        mode <= MODE_IDLE; // Halt wins over a pending command
                    end else if (cmd_port.cmd_valid && cmd_port.cmd == CMD_STEP) begin
                        mode       <= MODE_DUMP;
                        step_chain <= 1'b1;
                        o_step     <= 1'b1;
                        o_dump_req <= 1'b1;
                        o_dump_src <= SRC_PC;
                    end else if (cmd_port.cmd_valid && cmd_port.cmd == CMD_CONTINUE) begin
                        mode <= MODE_RUN;
                    end
                end

                MODE_DUMP: begin
                    if (i_dump_done) begin
                        if (!step_chain) begin
                            mode <= MODE_IDLE;
                        end else if (o_dump_src == SRC_RB) begin
                            // Chain finished
                            mode       <= MODE_STEP;
                            step_chain <= 1'b0;
                        end else begin
                            // PC then DM then RB
                            o_dump_req <= 1'b1;
                            o_dump_src <= (o_dump_src == SRC_PC) ? SRC_DM : SRC_RB;
                        end
                    end
                end

                default: mode <= MODE_IDLE;
            endcase
        end
    end

    assign cmd_port.load_active = (mode == MODE_LOAD);

    // Pipeline frozen while dumping
    assign o_pipeline_enable = (mode == MODE_RUN) || (mode == MODE_STEP);
    assign o_step_mode       = (mode == MODE_STEP) || (mode == MODE_DUMP && step_chain);

endmodule

// File: hdl/dump_serializer.sv
module dump_serializer
    import dbg_target_pkg::*;
    import dbg_protocol_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_dump_req,
    input  dump_src_t               i_dump_src,
    output logic                    o_dump_done,
    input  word_t                   i_pc_value,
    input  word_t                   i_rb_data,
    input  word_t                   i_dm_data,
    output logic [RB_ADDR_BITS-1:0] o_rb_addr,
    output logic                    o_rb_read,
    output logic [DM_ADDR_BITS-1:0] o_dm_addr,
    output logic                    o_dm_read,
    input  logic                    i_tx_done,
    output byte_t                   o_tx_data,
    output logic                    o_tx_start
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,  // Address and read select seen by memory
        S_LATCH, // Read data valid
        S_LOAD,  // Next byte onto tx_data
        S_SEND   // Waiting on the transmitter
    } state_t;

    state_t                              state;
    dump_src_t                           src;
    logic [DM_ADDR_BITS-1:0]             word_idx;
    logic [DM_ADDR_BITS-1:0]             word_last;
    logic [$clog2(BYTES_PER_WORD)-1:0]   byte_idx;
    word_t                               word_q;
    word_t                               read_word;

    always_comb begin
        case (src)
            SRC_DM:  word_last = DM_ADDR_BITS'(DM_DEPTH - 1);
            SRC_RB:  word_last = DM_ADDR_BITS'(RB_DEPTH - 1);
            default: word_last = '0; // PC is a single word
        endcase
    end

    always_comb begin
        case (src)
            SRC_DM:  read_word = i_dm_data;
            SRC_RB:  read_word = i_rb_data;
            default: read_word = i_pc_value;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state       <= S_IDLE;
            word_idx    <= '0;
            byte_idx    <= '0;
            o_rb_read   <= 1'b0;
            o_dm_read   <= 1'b0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (i_dump_req) begin
                        word_idx  <= '0;
                        byte_idx  <= '0;
                        o_rb_read <= (i_dump_src == SRC_RB); // Held for the whole dump
                        o_dm_read <= (i_dump_src == SRC_DM);
                        state     <= S_READ;
                    end
                end

                S_READ:  state <= S_LATCH;
                S_LATCH: state <= S_LOAD;

                S_LOAD: begin
                    o_tx_start <= 1'b1;
                    state      <= S_SEND;
                end

                S_SEND: begin
                    if (i_tx_done) begin
                        o_tx_start <= 1'b0; // Low at least one cycle between bytes
                        if (byte_idx == BYTES_PER_WORD - 1) begin
                            byte_idx <= '0;
                            if (word_idx == word_last) begin
                                o_dump_done <= 1'b1;
                                o_rb_read   <= 1'b0;
                                o_dm_read   <= 1'b0;
                                state       <= S_IDLE;
                            end else begin
                                word_idx <= word_idx + 1'b1;
                                state    <= S_READ;
                            end
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= S_LOAD;
                        end
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // Word shifts out MSB first
    always_ff @(posedge i_clock) begin
        if (state == S_IDLE && i_dump_req) begin
            src <= i_dump_src;
        end
        if (state == S_LATCH) begin
            word_q <= read_word;
        end else if (state == S_LOAD) begin
            word_q    <= word_q << BYTE_BITS;
            o_tx_data <= word_q[WORD_BITS-1 -: BYTE_BITS];
        end
    end

    assign o_rb_addr = word_idx[RB_ADDR_BITS-1:0];
    assign o_dm_addr = word_idx;

endmodule

// File: hdl/debug_unit.sv
module debug_unit
    import dbg_target_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_halt,
    input  logic                    i_rx_done,
    input  logic                    i_tx_done,
    input  byte_t                   i_rx_data,
    input  word_t                   i_pc_value,
    input  word_t                   i_rb_data,
    input  word_t                   i_dm_data,
    output logic                    o_im_write_enable,
    output logic [IM_ADDR_BITS-1:0] o_im_addr,
    output byte_t                   o_im_data,
    output logic [RB_ADDR_BITS-1:0] o_rb_addr,
    output logic                    o_rb_read,
    output logic [DM_ADDR_BITS-1:0] o_dm_addr,
    output logic                    o_dm_read,
    output byte_t                   o_tx_data,
    output logic                    o_tx_start,
    output logic                    o_pipeline_enable,
    output logic                    o_step,
    output logic                    o_step_mode
);

    // Sequencer to serializer
    logic                        dump_req;
    dbg_protocol_pkg::dump_src_t dump_src;
    logic                        dump_done;

    debug_cmd_if cmd_bus ();

    command_frontend u_frontend (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .cmd_port          (cmd_bus.frontend),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data)
    );

    debug_sequencer u_sequencer (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_halt            (i_halt),
        .cmd_port          (cmd_bus.sequencer),
        .o_dump_req        (dump_req),
        .o_dump_src        (dump_src),
        .i_dump_done       (dump_done),
        .o_pipeline_enable (o_pipeline_enable),
        .o_step            (o_step),
        .o_step_mode       (o_step_mode)
    );

    dump_serializer u_serializer (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_dump_req  (dump_req),
        .i_dump_src  (dump_src),
        .o_dump_done (dump_done),
        .i_pc_value  (i_pc_value),
        .i_rb_data   (i_rb_data),
        .i_dm_data   (i_dm_data),
        .o_rb_addr   (o_rb_addr),
        .o_rb_read   (o_rb_read),
        .o_dm_addr   (o_dm_addr),
        .o_dm_read   (o_dm_read),
        .i_tx_done   (i_tx_done),
        .o_tx_data   (o_tx_data),
        .o_tx_start  (o_tx_start)
    );

endmodule

// File: verif/debug_unit_tb.sv
module debug_unit_tb
    import dbg_target_pkg::*;
    import dbg_protocol_pkg::*;
();

    localparam int          HALF_PERIOD = 50;
    localparam int          DRIVE_DELAY = 10;
    localparam logic [31:0] SEED        = 32'd78144;
    localparam word_t       PC_VALUE    = 32'h0040_1f3c;
    localparam int          BYTE_GAP    = 3;  // Idle cycles after each received byte
    localparam int          SETTLE      = 8;
    localparam int          HALT_DELAY  = 20;
    localparam int          NUM_ROWS    = 12;

    typedef struct packed {
        command_t   cmd;
        logic       has_program;   // Program bytes follow
        logic       exp_enable;
        logic       exp_step_mode;
        logic       wait_halt;     // Run until the halt model stops it
        logic [1:0] exp_steps;
        logic [1:0] n_dumps;
        dump_src_t  dump0;
        dump_src_t  dump1;
        dump_src_t  dump2;
    } row_t;

    localparam row_t COMMANDS [NUM_ROWS] = '{
        '{CMD_START,     1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_SEND_PC,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd1, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_SEND_RB,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd1, SRC_RB, SRC_PC, SRC_PC},
        '{CMD_SEND_DM,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd1, SRC_DM, SRC_PC, SRC_PC},
        '{CMD_WRITE_IM,  1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_START,     1'b0, 1'b1, 1'b0, 1'b1, 2'd0, 2'd0, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_SEND_PC,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'd1, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_WRITE_IM,  1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_STEP_MODE, 1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 2'd0, SRC_PC, SRC_PC, SRC_PC},
        '{CMD_STEP,      1'b0, 1'b1, 1'b1, 1'b0, 2'd1, 2'd3, SRC_PC, SRC_DM, SRC_RB},
        '{CMD_STEP,      1'b0, 1'b1, 1'b1, 1'b0, 2'd1, 2'd3, SRC_PC, SRC_DM, SRC_RB},
        '{CMD_CONTINUE,  1'b0, 1'b1, 1'b0, 1'b1, 2'd0, 2'd0, SRC_PC, SRC_PC, SRC_PC}
    };

    logic                    i_clock;
    logic                    i_reset;
    logic                    i_halt;
    logic                    i_rx_done;
    logic                    i_tx_done;
    byte_t                   i_rx_data;
    word_t                   i_pc_value;
    word_t                   i_rb_data;
    word_t                   i_dm_data;
    logic                    o_im_write_enable;
    logic [IM_ADDR_BITS-1:0] o_im_addr;
    byte_t                   o_im_data;
    logic [RB_ADDR_BITS-1:0] o_rb_addr;
    logic                    o_rb_read;
    logic [DM_ADDR_BITS-1:0] o_dm_addr;
    logic                    o_dm_read;
    byte_t                   o_tx_data;
    logic                    o_tx_start;
    logic                    o_pipeline_enable;
    logic                    o_step;
    logic                    o_step_mode;

    word_t                   rb_mem [RB_DEPTH];
    word_t                   dm_mem [DM_DEPTH];
    byte_t                   tx_bytes [$];  // Seen by the UART model
    byte_t                   exp_bytes [$];
    byte_t                   prog_bytes [$];
    logic [IM_ADDR_BITS-1:0] im_addrs [$];
    byte_t                   im_datas [$];
    logic [31:0]             fill_state;
    int                      step_count;
    int                      checks;
    int                      errors;
    int                      cycle_count;
    int                      cycle_limit;

    debug_unit uut (.*);

    initial begin
        i_clock = 1'b0;
        forever #HALF_PERIOD i_clock = ~i_clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic dump_src_t dump_at(input row_t r, input int k);
        case (k)
            0:       return r.dump0;
            1:       return r.dump1;
            default: return r.dump2;
        endcase
    endfunction

    function automatic int src_bytes(input dump_src_t src);
        case (src)
            SRC_DM:  return DM_DEPTH * BYTES_PER_WORD;
            SRC_RB:  return RB_DEPTH * BYTES_PER_WORD;
            default: return BYTES_PER_WORD;
        endcase
    endfunction

    // Inputs change a little after the rising edge
    task automatic tick();
        @(posedge i_clock);
        #DRIVE_DELAY;
    endtask

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error at time %0t: %s", $time, what);
        end
    endtask

    task automatic send_byte(input byte_t b);
        i_rx_done = 1'b1;
        i_rx_data = b;
        tick();
        i_rx_done = 1'b0;
        repeat (BYTE_GAP) tick();
    endtask

    task automatic append_word(input word_t w);
        for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
            exp_bytes.push_back(w[b*BYTE_BITS +: BYTE_BITS]); // MSB first
        end
    endtask

    task automatic append_source(input dump_src_t src);
        case (src)
            SRC_DM:  for (int i = 0; i < DM_DEPTH; i++) append_word(dm_mem[i]);
            SRC_RB:  for (int i = 0; i < RB_DEPTH; i++) append_word(rb_mem[i]);
            default: append_word(PC_VALUE);
        endcase
    endtask

    task automatic apply_row(input row_t r);
        tx_bytes.delete();
        exp_bytes.delete();
        prog_bytes.delete();
        im_addrs.delete();
        im_datas.delete();
        step_count = 0;
        for (int k = 0; k < r.n_dumps; k++) append_source(dump_at(r, k));

        send_byte(r.cmd);
        if (r.has_program) begin
            for (int i = 0; i < IM_DEPTH; i++) begin
                fill_state = xorshift(fill_state);
                prog_bytes.push_back(fill_state[7:0]);
                send_byte(fill_state[7:0]);
            end
        end
        while (tx_bytes.size() < exp_bytes.size()) tick();
        repeat (SETTLE) tick();

        check(tx_bytes.size() == exp_bytes.size(),
              $sformatf("cmd %0d: %0d dump bytes, expected %0d",
                        r.cmd, tx_bytes.size(), exp_bytes.size()));
        for (int i = 0; i < exp_bytes.size() && i < tx_bytes.size(); i++) begin
            check(tx_bytes[i] === exp_bytes[i],
                  $sformatf("cmd %0d: dump byte %0d is %h, expected %h",
                            r.cmd, i, tx_bytes[i], exp_bytes[i]));
        end
        if (r.has_program) begin
            check(im_addrs.size() == IM_DEPTH,
                  $sformatf("%0d program writes, expected %0d", im_addrs.size(), IM_DEPTH));
            for (int i = 0; i < IM_DEPTH && i < im_addrs.size(); i++) begin
                check(im_addrs[i] == i && im_datas[i] === prog_bytes[i],
                      $sformatf("program write %0d to %0d with %h, expected %h",
                                i, im_addrs[i], im_datas[i], prog_bytes[i]));
            end
        end
        check(step_count == r.exp_steps,
              $sformatf("cmd %0d: %0d step pulses, expected %0d", r.cmd, step_count, r.exp_steps));
        check(o_pipeline_enable === r.exp_enable,
              $sformatf("cmd %0d: pipeline enable %b, expected %b",
                        r.cmd, o_pipeline_enable, r.exp_enable));
        check(o_step_mode === r.exp_step_mode,
              $sformatf("cmd %0d: step mode %b, expected %b",
                        r.cmd, o_step_mode, r.exp_step_mode));
        if (r.wait_halt) begin
            while (o_pipeline_enable) tick(); // Halt model ends the run
            repeat (2) tick();
        end
    endtask

    // UART transmitter with a random done delay
    initial begin
        logic [31:0] tx_state;
        int          delay;
        i_tx_done = 1'b0;
        tx_state  = SEED;
        forever begin
            tick();
            if (o_tx_start) begin
                tx_bytes.push_back(o_tx_data);
                tx_state = xorshift(tx_state);
                delay    = 1 + int'(tx_state % 4);
                repeat (delay) tick();
                i_tx_done = 1'b1;
                tick();
                i_tx_done = 1'b0;
                while (o_tx_start) tick();
            end
        end
    end

    // Register bank and data memory, one cycle read latency
    initial begin
        logic [RB_ADDR_BITS-1:0] rb_addr_q;
        logic [DM_ADDR_BITS-1:0] dm_addr_q;
        logic                    rb_read_q;
        logic                    dm_read_q;
        i_rb_data = '0;
        i_dm_data = '0;
        rb_read_q = 1'b0;
        dm_read_q = 1'b0;
        forever begin
            tick();
            i_rb_data = rb_read_q ? rb_mem[rb_addr_q] : 'x;
            i_dm_data = dm_read_q ? dm_mem[dm_addr_q] : 'x;
            rb_addr_q = o_rb_addr;
            rb_read_q = o_rb_read;
            dm_addr_q = o_dm_addr;
            dm_read_q = o_dm_read;
        end
    end

    // Halt some cycles into a free run
    initial begin
        int run_cycles;
        i_halt     = 1'b0;
        run_cycles = 0;
        forever begin
            tick();
            if (o_pipeline_enable && !o_step_mode) run_cycles++;
            else run_cycles = 0;
            i_halt = (run_cycles == HALT_DELAY);
        end
    end

    // Program writes, step pulses and frozen pipeline while sending
    initial begin
        forever begin
            tick();
            if (o_im_write_enable) begin
                im_addrs.push_back(o_im_addr);
                im_datas.push_back(o_im_data);
            end
            if (o_step) step_count++;
            if (o_tx_start) check(!o_pipeline_enable, "pipeline enable high during a dump");
        end
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            tick();
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        i_reset     = 1'b1;
        i_rx_done   = 1'b0;
        i_rx_data   = '0;
        i_pc_value  = PC_VALUE;
        checks      = 0;
        errors      = 0;
        step_count  = 0;
        cycle_limit = 0;
        fill_state  = SEED;
        for (int i = 0; i < RB_DEPTH; i++) begin
            fill_state = xorshift(fill_state);
            rb_mem[i]  = fill_state;
        end
        for (int i = 0; i < DM_DEPTH; i++) begin
            fill_state = xorshift(fill_state);
            dm_mem[i]  = fill_state;
        end

        // Budget from the table
        cycle_limit = 1000;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < COMMANDS[r].n_dumps; k++) begin
                cycle_limit += src_bytes(dump_at(COMMANDS[r], k)) * 8;
            end
            if (COMMANDS[r].has_program) cycle_limit += IM_DEPTH * 4;
        end

        repeat (2) tick();
        i_reset = 1'b0;
        check(!o_pipeline_enable && !o_step && !o_step_mode && !o_tx_start &&
              !o_im_write_enable && !o_rb_read && !o_dm_read,
              "control outputs not low after reset");
        check(uut.u_sequencer.mode == MODE_IDLE, "mode not idle after reset");

        for (int r = 0; r < NUM_ROWS; r++) apply_row(COMMANDS[r]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: debug_unit.f
hdl/dbg_target_pkg.sv
hdl/dbg_protocol_pkg.sv
hdl/debug_cmd_if.sv
hdl/command_frontend.sv
hdl/debug_sequencer.sv
hdl/dump_serializer.sv
hdl/debug_unit.sv
verif/debug_unit_tb.sv

// File: Bender.yml
package:
  name: debug_unit

sources:
  - hdl/dbg_target_pkg.sv
  - hdl/dbg_protocol_pkg.sv
  - hdl/debug_cmd_if.sv
  - hdl/command_frontend.sv
  - hdl/debug_sequencer.sv
  - hdl/dump_serializer.sv
  - hdl/debug_unit.sv
  - target: test
    files:
      - verif/debug_unit_tb.sv
